/* f2h_stream.f */
src/f2h_pkg.sv
src/ctrl_regs.sv
src/pattern_fill.sv
src/row_ram.sv
src/burst_planner.sv
src/axi_burst_writer.sv
src/f2h_stream_top.sv
sim/axi_mem_model.sv
sim/f2h_stream_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the f2h_stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module f2h_stream_tb \
	-f f2h_stream.f \
	-o f2h_stream_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/f2h_stream_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

/* sim/f2h_stream_tb.sv */
// ====================
// Testbench top: clock, reset, APB driver,
// transfer table, burst prediction, watchdog
// ====================
`timescale 1ns/1ps
`default_nettype none

module f2h_stream_tb import f2h_pkg::*; ();

	localparam int          mem_addr_width = 3;
	localparam int          row_count      = 2 ** mem_addr_width;
	localparam int          beat_bytes     = 4;
	localparam int          full_beats     = 4;
	// Row r holds counter values r*8 up to r*8+7
	localparam int          words_per_row  = 8;
	localparam logic [31:0] host_base      = 32'h8000_0000;
	localparam int          num_xfers      = 9;

	typedef struct packed {
		logic [31:0] offset;
		logic [31:0] len;
		logic        rdy_bit;
		logic        stall;
		logic [3:0]  bursts;
	} xfer_t;

	// Offset, length, ready bit, stalls, expected bursts
	// Rows used add up to 16 before entry 7, so 7 and 8 repeat 0 and 1 under stalls
	xfer_t xfers [num_xfers] = '{
		'{32'h0000_1000, 32'd64, 1'b0, 1'b0, 4'd4},
		'{32'h0000_2000, 32'd24, 1'b1, 1'b0, 4'd2},
		'{32'h0000_0000, 32'd32, 1'b0, 1'b0, 4'd2},
		'{32'h0000_3000, 32'd24, 1'b1, 1'b0, 4'd2},
		'{32'h0000_4000, 32'd40, 1'b0, 1'b0, 4'd3},
		'{32'h0000_5000, 32'd12, 1'b1, 1'b0, 4'd1},
		'{32'h0000_6000, 32'd32, 1'b0, 1'b0, 4'd2},
		'{32'h0000_1000, 32'd64, 1'b1, 1'b1, 4'd4},
		'{32'h0000_2000, 32'd24, 1'b0, 1'b1, 4'd2}
	};

	logic        pll0_clock0;
	logic        master_reset_n;
	logic        stall_en;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	axi_aw_t     aw;
	logic        aw_valid;
	logic        aw_ready;
	axi_w_t      w;
	logic        w_valid;
	logic        w_ready;
	axi_b_t      b;
	logic        b_valid;
	logic        b_ready;
	logic        irq;
	int          error_count;
	int          pred_row;
	logic [31:0] exp_addr_q [$];
	int          exp_beats_q [$];
	logic [31:0] exp_data_q [$];
	logic        exp_last_q [$];

	f2h_stream_top #(.MEM_ADDR_WIDTH(mem_addr_width)) DUT (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.apb_req        (apb_req),
		.aw_ready       (aw_ready),
		.w_ready        (w_ready),
		.b              (b),
		.b_valid        (b_valid),
		.apb_rsp        (apb_rsp),
		.aw             (aw),
		.aw_valid       (aw_valid),
		.w              (w),
		.w_valid        (w_valid),
		.b_ready        (b_ready),
		.irq            (irq)
	);

	axi_mem_model mem_model (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.stall_en       (stall_en),
		.aw             (aw),
		.aw_valid       (aw_valid),
		.w              (w),
		.w_valid        (w_valid),
		.b_ready        (b_ready),
		.aw_ready       (aw_ready),
		.w_ready        (w_ready),
		.b              (b),
		.b_valid        (b_valid)
	);

	initial pll0_clock0 = 1'b0;
	always #10 pll0_clock0 = ~pll0_clock0;

	// ====================
	// Helpers
	// ====================
	task automatic next_cycle();
		@(posedge pll0_clock0);
		#1;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Done: errors found");
			$fatal(1, "Check failed on %s", name);
		end
	endtask

	// Setup phase, then access phase
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		next_cycle();
		apb_req.penable = 1'b1;
		next_cycle();
		apb_req = '0;
	endtask

	// Response sampled mid access cycle
	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output logic err);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		next_cycle();
		apb_req.penable = 1'b1;
		#5;
		data = apb_rsp.prdata;
		err  = apb_rsp.pslverr;
		// No wait states
		compare_value("apb_rsp.pready", 32'(apb_rsp.pready), 32'd1);
		next_cycle();
		apb_req = '0;
	endtask

	// Bursts of up to four beats, one RAM row each, row pointer carried over
	task automatic predict_bursts(input logic [31:0] offset, input logic [31:0] len);
		logic [31:0] addr;
		int          remain;
		int          beats;
		addr   = host_base + offset;
		remain = int'(len);
		exp_addr_q.delete();
		exp_beats_q.delete();
		exp_data_q.delete();
		exp_last_q.delete();
		while (remain > 0) begin
			beats = (remain >= full_beats * beat_bytes) ? full_beats : remain / beat_bytes;
			exp_addr_q.push_back(addr);
			exp_beats_q.push_back(beats);
			// Two counter words per beat, lower word in the low half
			for (int k = 0; k < beats; k++) begin
				exp_data_q.push_back({16'(pred_row * words_per_row + 2 * k + 1),
					16'(pred_row * words_per_row + 2 * k)});
				exp_last_q.push_back(k == beats - 1);
			end
			addr     = addr + 32'(beats * beat_bytes);
			remain   = remain - beats * beat_bytes;
			pred_row = (pred_row + 1) % row_count;
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin : stimulus
		logic [31:0] rd;
		logic        err;
		int          burst0;
		int          beat0;
		int          resp0;
		axi_aw_t     got_aw;
		axi_w_t      got_w;
		apb_req        = '0;
		stall_en       = 1'b0;
		master_reset_n = 1'b0;
		error_count    = 0;
		pred_row       = 0;
		repeat (8) @(posedge pll0_clock0);
		#1;
		master_reset_n = 1'b1;

		// Quiet outputs, fill still running
		compare_value("irq", 32'(irq), 32'd0);
		compare_value("aw_valid", 32'(aw_valid), 32'd0);
		compare_value("w_valid", 32'(w_valid), 32'd0);
		compare_value("b_ready", 32'(b_ready), 32'd0);
		read_reg(reg_status, rd, err);
		compare_value("status.fill_done early", 32'(rd[0]), 32'd0);
		// Fill takes 72 cycles, sampled near cycle 77
		repeat (74) next_cycle();
		read_reg(reg_status, rd, err);
		compare_value("status.fill_done", 32'(rd[0]), 32'd1);

		// Register readback and decode errors
		write_reg(reg_addr, 32'h0000_0abc);
		read_reg(reg_addr, rd, err);
		compare_value("reg_addr", rd, 32'h0000_0abc);
		compare_value("pslverr reg_addr", 32'(err), 32'd0);
		write_reg(reg_len, 32'd64);
		read_reg(reg_len, rd, err);
		compare_value("reg_len", rd, 32'd64);
		// Bit 1 alone while index 0 is active
		write_reg(reg_rdy, 32'd2);
		read_reg(reg_rdy, rd, err);
		compare_value("reg_rdy", rd, 32'd2);
		write_reg(reg_rdy, 32'd0);
		write_reg(reg_status, 32'hffff_ffff);
		read_reg(reg_status, rd, err);
		compare_value("reg_status", rd, 32'd1);
		read_reg(4'h3, rd, err);
		compare_value("pslverr unmapped", 32'(err), 32'd1);
		compare_value("aw count idle", 32'(mem_model.aw_count), 32'd0);

		for (int i = 0; i < num_xfers; i++) begin
			burst0   = mem_model.aw_count;
			beat0    = mem_model.w_count;
			resp0    = mem_model.b_count;
			stall_en = xfers[i].stall;
			write_reg(reg_addr, xfers[i].offset);
			write_reg(reg_len, xfers[i].len);
			read_reg(reg_status, rd, err);
			compare_value("status.rdy_index", 32'(rd[2]), 32'(xfers[i].rdy_bit));
			// Wrong flag must start nothing
			write_reg(reg_rdy, xfers[i].rdy_bit ? 32'd1 : 32'd2);
			repeat (10) next_cycle();
			read_reg(reg_status, rd, err);
			compare_value("status.busy idle", 32'(rd[1]), 32'd0);
			compare_value("aw count idle", 32'(mem_model.aw_count - burst0), 32'd0);
			write_reg(reg_rdy, xfers[i].rdy_bit ? 32'd2 : 32'd1);
			predict_bursts(xfers[i].offset, xfers[i].len);
			while (!irq)
				next_cycle();

			// First cycle of irq, every response already in
			compare_value("responses at irq", 32'(mem_model.b_count - resp0),
				32'(exp_addr_q.size()));
			compare_value("burst count", 32'(mem_model.aw_count - burst0),
				32'(xfers[i].bursts));
			for (int j = 0; j < exp_addr_q.size(); j++) begin
				got_aw = mem_model.aw_log[burst0 + j];
				compare_value($sformatf("aw.addr[%0d]", j), got_aw.addr, exp_addr_q[j]);
				compare_value($sformatf("aw.len[%0d]", j), 32'(got_aw.len),
					32'(exp_beats_q[j] - 1));
				// Zero id, 4-byte beats, INCR, normal lock, fixed cache/prot/user
				compare_value($sformatf("aw attributes[%0d]", j),
					32'({got_aw.id, got_aw.size, got_aw.burst, got_aw.lock,
						got_aw.cache, got_aw.prot, got_aw.user}),
					32'({8'd0, 3'd2, 2'b01, 2'b00, axi_cache_wb_wa,
						axi_prot_data_secure, axi_user_shared_wb_wa}));
				compare_value($sformatf("beats[%0d]", j), 32'(mem_model.beats_log[burst0 + j]),
					32'(exp_beats_q[j]));
			end
			compare_value("beat count", 32'(mem_model.w_count - beat0),
				32'(exp_data_q.size()));
			for (int j = 0; j < exp_data_q.size(); j++) begin
				got_w = mem_model.w_log[beat0 + j];
				compare_value($sformatf("w.data[%0d]", j), got_w.data, exp_data_q[j]);
				// Zero id, all byte lanes, last only on the final beat of a burst
				compare_value($sformatf("w.id/strb/last[%0d]", j),
					32'({got_w.id, got_w.strb, got_w.last}),
					32'({8'd0, 4'hf, exp_last_q[j]}));
			end

			// Still busy until the host clears the flag
			read_reg(reg_status, rd, err);
			compare_value("status.busy at irq", 32'(rd[1]), 32'd1);

			// Clear the active flag, sequencer moves on
			write_reg(reg_rdy, 32'd0);
			next_cycle();
			compare_value("irq after clear", 32'(irq), 32'd0);
			read_reg(reg_status, rd, err);
			compare_value("status.rdy_index next", 32'(rd[2]), 32'(!xfers[i].rdy_bit));
			compare_value("status.busy done", 32'(rd[1]), 32'd0);
		end

		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

	// ====================
	// Watchdog
	// ====================
	initial begin : watchdog
		int limit;
		limit = 2000;
		foreach (xfers[i])
			limit += int'(xfers[i].len) * 20;
		repeat (limit) @(posedge pll0_clock0);
		$display("Watchdog expired after %0d cycles before the tests finished", limit);
		$display("Done: errors found");
		$fatal(1, "Simulation timed out");
	end

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
// ====================
// AXI write slave model with seeded random
// ready stalls and a burst and beat log
// ====================
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import f2h_pkg::*; (
	input  wire          pll0_clock0,
	input  wire          master_reset_n,
	input  wire          stall_en,
	input  wire axi_aw_t aw,
	input  wire          aw_valid,
	input  wire axi_w_t  w,
	input  wire          w_valid,
	input  wire          b_ready,
	output logic         aw_ready,
	output logic         w_ready,
	output axi_b_t       b,
	output logic         b_valid
);

	integer      seed;
	int          aw_count;
	int          w_count;
	int          b_count;
	logic        resp_due;
	logic        resp_taken;
	logic [31:0] stall_draw;
	// One entry per accepted address
	axi_aw_t     aw_log [64];
	int          beats_log [64];
	// One entry per accepted beat, in arrival order
	axi_w_t      w_log [256];

	initial begin
		seed       = 32'h36c2_2652;
		aw_count   = 0;
		w_count    = 0;
		b_count    = 0;
		resp_due   = 1'b0;
		resp_taken = 1'b0;
		aw_ready   = 1'b0;
		w_ready    = 1'b0;
		b          = '0;
		b_valid    = 1'b0;
		forever begin
			@(posedge pll0_clock0);
			// ====================
			// Handshakes seen at this edge
			// ====================
			resp_taken = b_valid && b_ready;
			if (master_reset_n) begin
				if (aw_valid && aw_ready) begin
					aw_log[aw_count]    = aw;
					beats_log[aw_count] = 0;
					aw_count++;
				end
				if (w_valid && w_ready) begin
					w_log[w_count] = w;
					w_count++;
					// Beats belong to the newest address
					beats_log[aw_count - 1]++;
					if (w.last)
						resp_due = 1'b1;
				end
				if (resp_taken)
					b_count++;
			end
			#1;
			// Response held until taken, always OKAY with id zero
			if (resp_taken)
				b_valid = 1'b0;
			if (resp_due) begin
				b_valid  = 1'b1;
				resp_due = 1'b0;
			end
			// Coin flip per cycle, drawn every cycle so the sequence stays fixed
			stall_draw = $random(seed);
			aw_ready   = stall_en ? stall_draw[0] : 1'b1;
			w_ready    = stall_en ? stall_draw[1] : 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/f2h_stream_top.sv */
// ====================
// Top level: registers, fill engine, RAM,
// sequencer and AXI writer
// ====================
`timescale 1ns/1ps
`default_nettype none

module f2h_stream_top import f2h_pkg::*; #(
	parameter int MEM_ADDR_WIDTH = 3
) (
	input  wire            pll0_clock0,
	input  wire            master_reset_n,
	input  wire apb_req_t  apb_req,
	input  wire            aw_ready,
	input  wire            w_ready,
	input  wire axi_b_t    b,
	input  wire            b_valid,
	output apb_rsp_t       apb_rsp,
	output axi_aw_t        aw,
	output logic           aw_valid,
	output axi_w_t         w,
	output logic           w_valid,
	output logic           b_ready,
	output logic           irq
);

	host_cfg_t                 host_cfg;
	burst_cmd_t                cmd;
	wr_status_e                wr_status;
	logic [MEM_ADDR_WIDTH-1:0] waddr;
	logic [MEM_ADDR_WIDTH-1:0] raddr;
	logic [row_bits-1:0]       wdata;
	logic [row_bits-1:0]       rdata;
	logic                      we;
	logic                      fill_done;
	logic                      busy;
	logic                      rdy_index;

	// Host control registers
	ctrl_regs u_ctrl_regs (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.apb_req        (apb_req),
		.fill_done      (fill_done),
		.busy           (busy),
		.rdy_index      (rdy_index),
		.apb_rsp        (apb_rsp),
		.host_cfg       (host_cfg)
	);

	// Test pattern source
	pattern_fill #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_pattern_fill (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.waddr          (waddr),
		.wdata          (wdata),
		.we             (we),
		.fill_done      (fill_done)
	);

	row_ram #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_row_ram (
		.pll0_clock0 (pll0_clock0),
		.waddr       (waddr),
		.wdata       (wdata),
		.we          (we),
		.raddr       (raddr),
		.rdata       (rdata)
	);

	burst_planner #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_burst_planner (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.host_cfg       (host_cfg),
		.fill_done      (fill_done),
		.wr_status      (wr_status),
		.cmd            (cmd),
		.raddr          (raddr),
		.busy           (busy),
		.rdy_index      (rdy_index),
		.irq            (irq)
	);

	// AXI write channels to the host port
	axi_burst_writer u_axi_burst_writer (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.cmd            (cmd),
		.rdata          (rdata),
		.aw_ready       (aw_ready),
		.w_ready        (w_ready),
		.b              (b),
		.b_valid        (b_valid),
		.wr_status      (wr_status),
		.aw             (aw),
		.aw_valid       (aw_valid),
		.w              (w),
		.w_valid        (w_valid),
		.b_ready        (b_ready)
	);

endmodule

`default_nettype wire

/* src/axi_burst_writer.sv */
// ====================
// AXI write master: one address, its beats,
// then the write response
// ====================
`timescale 1ns/1ps
`default_nettype none

module axi_burst_writer import f2h_pkg::*; (
	input  wire                 pll0_clock0,
	input  wire                 master_reset_n,
	input  wire burst_cmd_t     cmd,
	input  wire [row_bits-1:0]  rdata,
	input  wire                 aw_ready,
	input  wire                 w_ready,
	input  wire axi_b_t         b,
	input  wire                 b_valid,
	output wr_status_e          wr_status,
	output axi_aw_t             aw,
	output logic                aw_valid,
	output axi_w_t              w,
	output logic                w_valid,
	output logic                b_ready
);

	logic [row_bits-1:0] row;
	logic [31:0]         addr;
	logic [3:0]          beats_m1;
	logic [3:0]          beat;
	logic                last_beat;

	assign last_beat = (beat == beats_m1);

	// Fixed attributes, id always zero
	assign aw = '{
		id:    '0,
		addr:  addr,
		len:   beats_m1,
		size:  axi_size_bus,
		burst: axi_burst_incr,
		lock:  axi_lock_normal,
		cache: axi_cache_wb_wa,
		prot:  axi_prot_data_secure,
		user:  axi_user_shared_wb_wa
	};

	// Beat k is slice k of the latched row
	assign w = '{
		id:   '0,
		data: row[beat*bus_bits +: bus_bits],
		strb: '1,
		last: last_beat
	};

	// ====================
	// Burst FSM
	// ====================
	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			wr_status <= wr_idle;
			aw_valid  <= 1'b0;
			w_valid   <= 1'b0;
			b_ready   <= 1'b0;
			beat      <= '0;
		end else begin
			case (wr_status)
				wr_idle: begin
					if (cmd.enable) begin
						aw_valid  <= 1'b1;
						beat      <= '0;
						wr_status <= wr_busy;
					end
				end
				wr_busy: begin
					// Address first, data only after it is accepted
					if (aw_valid && aw_ready) begin
						aw_valid <= 1'b0;
						w_valid  <= 1'b1;
					end
					if (w_valid && w_ready) begin
						if (last_beat) begin
							w_valid <= 1'b0;
							b_ready <= 1'b1;
						end else begin
							beat <= beat + 1'b1;
						end
					end
					// Response taken as is
					if (b_ready && b_valid) begin
						b_ready   <= 1'b0;
						wr_status <= wr_done;
					end
				end
				// wr_done holds for one cycle only
				default: wr_status <= wr_idle;
			endcase
		end
	end

	// Latch row and command on burst start
	always_ff @(posedge pll0_clock0) begin
		if (wr_status == wr_idle && cmd.enable) begin
			row      <= rdata;
			addr     <= cmd.addr;
			beats_m1 <= cmd.beats_m1;
		end
	end

	assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw));

	assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		w_valid && !w_ready |=> w_valid && $stable(w));

	// Slave must echo the zero write id
	assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		b_valid && b_ready |-> b.id == 8'd0);

endmodule

`default_nettype wire

/* src/burst_planner.sv */
// ====================
// Transfer sequencer: ready flag tracking,
// burst address and length, row pointer, IRQ
// ====================
`timescale 1ns/1ps
`default_nettype none

module burst_planner import f2h_pkg::*; #(
	parameter int MEM_ADDR_WIDTH = 3
) (
	input  wire                       pll0_clock0,
	input  wire                       master_reset_n,
	input  wire host_cfg_t            host_cfg,
	input  wire                       fill_done,
	input  wire wr_status_e           wr_status,
	output burst_cmd_t                cmd,
	output logic [MEM_ADDR_WIDTH-1:0] raddr,
	output logic                      busy,
	output logic                      rdy_index,
	output logic                      irq
);

	logic [31:0]               remain_len;
	logic [31:0]               burst_bytes;
	logic [31:0]               next_len;
	logic [MEM_ADDR_WIDTH-1:0] row_ptr;
	logic                      rdy_sel;
	logic                      start;
	logic                      burst_end;

	// Full burst, or whatever is left when shorter
	function automatic logic [3:0] beats_for(input logic [31:0] len);
		if (len == 32'd0)
			return 4'd0;
		if (len >= 32'(bus_bytes * max_burst))
			return 4'(max_burst - 1);
		return 4'(len / bus_bytes - 1);
	endfunction

	assign rdy_sel     = host_cfg.rdy[rdy_index];
	assign start       = fill_done && !busy && rdy_sel;
	assign burst_end   = cmd.enable && (wr_status == wr_done);
	assign burst_bytes = (32'(cmd.beats_m1) + 32'd1) * bus_bytes;
	assign next_len    = remain_len - burst_bytes;

	// Look one row ahead during wr_done
	// so the registered read is ready in the following idle cycle
	assign raddr = burst_end ? row_ptr + 1'b1 : row_ptr;

	// ====================
	// Sequencer
	// ====================
	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			cmd        <= '0;
			remain_len <= '0;
			row_ptr    <= '0;
			busy       <= 1'b0;
			rdy_index  <= 1'b0;
			irq        <= 1'b0;
		end else begin
			// Host raised the selected ready flag
			if (start) begin
				busy       <= 1'b1;
				remain_len <= host_cfg.len;
				cmd        <= '{
					enable:   host_cfg.len != 32'd0,
					addr:     acp_port_base + host_cfg.addr,
					beats_m1: beats_for(host_cfg.len)
				};
			end else if (burst_end) begin
				// Next burst follows on from the previous one
				remain_len   <= next_len;
				cmd.addr     <= cmd.addr + burst_bytes;
				cmd.beats_m1 <= beats_for(next_len);
				row_ptr      <= row_ptr + 1'b1;
				if (next_len == 32'd0) begin
					cmd.enable <= 1'b0;
					irq        <= 1'b1;
				end
			end

			// Host cleared the flag, move to the other one
			if (busy && !rdy_sel) begin
				irq       <= 1'b0;
				busy      <= 1'b0;
				rdy_index <= ~rdy_index;
			end
		end
	end

	// A row never holds more than one full burst
	assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		cmd.enable |-> cmd.beats_m1 <= 4'(max_burst - 1));

endmodule

`default_nettype wire

/* src/row_ram.sv */
// ====================
// Simple dual-port RAM, one burst per row
// ====================
`timescale 1ns/1ps
`default_nettype none

module row_ram import f2h_pkg::*; #(
	parameter int MEM_ADDR_WIDTH = 3
) (
	input  wire                      pll0_clock0,
	input  wire [MEM_ADDR_WIDTH-1:0] waddr,
	input  wire [row_bits-1:0]       wdata,
	input  wire                      we,
	input  wire [MEM_ADDR_WIDTH-1:0] raddr,
	output logic [row_bits-1:0]      rdata
);

	// Block RAM inference, array has no reset
	logic [row_bits-1:0] mem [2**MEM_ADDR_WIDTH];

	always_ff @(posedge pll0_clock0) begin
		if (we)
			mem[waddr] <= wdata;
		// Registered read, one clock after raddr
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* src/pattern_fill.sv */
// ====================
// Fill engine loading the RAM with a rising
// 16-bit counter, one row at a time
// ====================
`timescale 1ns/1ps
`default_nettype none

module pattern_fill import f2h_pkg::*; #(
	parameter int MEM_ADDR_WIDTH = 3
) (
	input  wire                       pll0_clock0,
	input  wire                       master_reset_n,
	output logic [MEM_ADDR_WIDTH-1:0] waddr,
	output logic [row_bits-1:0]       wdata,
	output logic                      we,
	output logic                      fill_done
);

	localparam int words_per_row = row_bits / word_bits;
	localparam int word_sel_bits = $clog2(words_per_row);

	logic [word_sel_bits-1:0] word_sel;
	logic [word_bits-1:0]     count;

	// Eight word cycles then one write cycle per row
	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			waddr     <= '0;
			we        <= 1'b0;
			fill_done <= 1'b0;
			word_sel  <= '0;
			count     <= '0;
		end else if (!fill_done) begin
			if (we) begin
				we    <= 1'b0;
				waddr <= waddr + 1'b1;
				// Last row written, address about to wrap
				if (&waddr)
					fill_done <= 1'b1;
			end else begin
				// Word select wraps back to zero on its own
				word_sel <= word_sel + 1'b1;
				count    <= count + 1'b1;
				if (&word_sel)
					we <= 1'b1;
			end
		end
	end

	// Row assembly, lowest word first
	always_ff @(posedge pll0_clock0) begin
		if (!fill_done && !we)
			wdata[word_sel*word_bits +: word_bits] <= count;
	end

endmodule

`default_nettype wire

/* src/ctrl_regs.sv */
// ====================
// APB slave with ready flags, target offset,
// byte length and status readback
// ====================
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import f2h_pkg::*; (
	input  wire              pll0_clock0,
	input  wire              master_reset_n,
	input  wire apb_req_t    apb_req,
	input  wire              fill_done,
	input  wire              busy,
	input  wire              rdy_index,
	output apb_rsp_t         apb_rsp,
	output host_cfg_t        host_cfg
);

	logic [1:0]  rdy_reg;
	logic [31:0] addr_reg;
	logic [31:0] len_reg;
	logic [31:0] rdata;
	logic        access;
	logic        mapped;

	// Second APB phase
	assign access = apb_req.psel && apb_req.penable;

	// ====================
	// Read mux and decode
	// ====================
	always_comb begin
		mapped = 1'b1;
		case (apb_req.paddr)
			reg_rdy:    rdata = {30'd0, rdy_reg};
			reg_addr:   rdata = addr_reg;
			reg_len:    rdata = len_reg;
			// Fill done, busy, active ready index
			reg_status: rdata = {29'd0, rdy_index, busy, fill_done};
			default: begin
				rdata  = '0;
				mapped = 1'b0;
			end
		endcase
	end

	// No wait states
	assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access && !mapped};

	// ====================
	// Register writes
	// ====================
	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			rdy_reg  <= '0;
			addr_reg <= '0;
			len_reg  <= '0;
		end else if (access && apb_req.pwrite) begin
			case (apb_req.paddr)
				reg_rdy:  rdy_reg  <= apb_req.pwdata[1:0];
				reg_addr: addr_reg <= apb_req.pwdata;
				reg_len:  len_reg  <= apb_req.pwdata;
				// Status is read only, unmapped offsets only flag an error
				default: begin
				end
			endcase
		end
	end

	assign host_cfg = '{rdy: rdy_reg, addr: addr_reg, len: len_reg};

	// Error only in an access phase that followed a setup phase
	assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		apb_rsp.pslverr |-> access && $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

/* src/f2h_pkg.sv */
// ====================
// Shared bus constants, AXI attribute codes,
// FSM and register enums, channel structs
// ====================
`default_nettype none

package f2h_pkg;

	// ====================
	// Bus geometry
	// ====================
	localparam int bus_bits  = 32;
	localparam int bus_bytes = bus_bits / 8;
	// One RAM row feeds exactly one full burst
	localparam int max_burst = 4;
	localparam int row_bits  = max_burst * bus_bits;
	localparam int word_bits = 16;

	// Host port (ACP window) base address
	localparam logic [31:0] acp_port_base = 32'h8000_0000;

	// ====================
	// AXI attributes
	// ====================
	// Outer cache write-back, write-allocate
	localparam logic [3:0] axi_cache_wb_wa       = 4'b1111;
	// Data access, secure, normal
	localparam logic [2:0] axi_prot_data_secure  = 3'b000;
	// Shared, inner write-back write-allocate
	localparam logic [4:0] axi_user_shared_wb_wa = 5'b11111;
	localparam logic [1:0] axi_burst_incr        = 2'b01;
	localparam logic [1:0] axi_lock_normal       = 2'b00;
	// Beat size code follows the bus width
	localparam logic [2:0] axi_size_bus          = 3'($clog2(bus_bytes));

	// Writer status, wr_done is a one-cycle pulse per burst
	typedef enum logic [1:0] {
		wr_idle = 2'd0,
		wr_busy = 2'd1,
		wr_done = 2'd2
	} wr_status_e;

	// APB register map
	typedef enum logic [3:0] {
		reg_rdy    = 4'h0,
		reg_addr   = 4'h4,
		reg_len    = 4'h8,
		reg_status = 4'hC
	} reg_addr_e;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [7:0]  id;
		logic [31:0] addr;
		logic [3:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
		logic [1:0]  lock;
		logic [3:0]  cache;
		logic [2:0]  prot;
		logic [4:0]  user;
	} axi_aw_t;

	typedef struct packed {
		logic [7:0]          id;
		logic [bus_bits-1:0] data;
		logic [bus_bytes-1:0] strb;
		logic                last;
	} axi_w_t;

	typedef struct packed {
		logic [7:0] id;
		logic [1:0] resp;
	} axi_b_t;

	// Sequencer to writer
	typedef struct packed {
		logic        enable;
		logic [31:0] addr;
		logic [3:0]  beats_m1;
	} burst_cmd_t;

	// Register block to sequencer
	typedef struct packed {
		logic [1:0]  rdy;
		logic [31:0] addr;
		logic [31:0] len;
	} host_cfg_t;

endpackage

`default_nettype wire
